// ==== sources.f ====
src/pkt_pkg.sv
src/rr_arbiter.sv
src/tx_packetizer.sv
src/tx_phy_framer.sv
src/rx_phy_deframer.sv
src/rx_depacketizer.sv
src/axi_mm_packet_master.sv
verification/tb_axi_mm_packet_master.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axi_mm_packet_master
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o sim
	./$(BUILD_DIR)/sim | tee $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_axi_mm_packet_master.sv ====
`timescale 1ns/100ps

module tb_axi_mm_packet_master
  import pkt_pkg::*;
();

  // One table row is one clock cycle
  // rx_credit is {w, aw, ar}
  typedef struct packed {
    logic       ar;
    logic       aw;
    logic       w;
    logic [1:0] rx_id;
    logic       rx_push;
    logic [2:0] rx_credit;
  } row_t;

  logic                 clk_wr;
  logic                 rst_wr_n;
  logic [AR_WIDTH-1:0]  tx_ar_data;
  logic                 tx_ar_pushbit;
  logic                 tx_ar_pop_ovrd;
  logic [AW_WIDTH-1:0]  tx_aw_data;
  logic                 tx_aw_pushbit;
  logic                 tx_aw_pop_ovrd;
  logic [W_WIDTH-1:0]   tx_w_data;
  logic                 tx_w_pushbit;
  logic                 tx_w_pop_ovrd;
  logic                 rx_ar_credit;
  logic                 rx_aw_credit;
  logic                 rx_w_credit;
  logic [R_WIDTH-1:0]   rx_r_data;
  logic                 rx_r_push_ovrd;
  logic                 rx_r_pushbit;
  logic [B_WIDTH-1:0]   rx_b_data;
  logic                 rx_b_push_ovrd;
  logic                 rx_b_pushbit;
  logic                 tx_r_credit;
  logic                 tx_b_credit;
  logic [PHY_WIDTH-1:0] tx_phy0;
  logic [PHY_WIDTH-1:0] rx_phy0;
  logic                 tx_stb_userbit;
  logic                 tx_mrk_userbit;

  // Reference state kept alongside the DUT
  logic [31:0]          rng_state;
  int                   ptr_m;
  logic                 mid_req_m;
  logic                 low_req_m;
  rx_pkt_e              prev_id_m;
  logic [PKT_WIDTH-1:0] prev_payload_m;
  logic                 ar_taken;
  logic                 aw_taken;
  logic                 w_taken;
  int                   mismatch_count;
  int                   timeout_count;
  int                   drain_limit = 24;

  //          ar aw w  id push crd
  row_t stim_table [32] = '{
    9'b0_0_0_00_0_000, 9'b1_0_0_00_1_001, 9'b0_0_0_01_1_010, 9'b0_1_0_10_0_100,
    9'b0_0_0_10_1_111, 9'b0_0_1_01_0_000, 9'b0_0_0_10_1_011, 9'b0_0_0_00_1_101,
    9'b0_0_0_00_0_000, 9'b1_0_0_01_1_110, 9'b0_0_0_10_0_001, 9'b1_1_1_00_1_010,
    9'b1_1_1_01_1_100, 9'b1_1_1_10_0_001, 9'b1_1_1_01_0_111, 9'b1_1_1_10_1_000,
    9'b1_1_1_00_0_110, 9'b1_1_1_01_1_011, 9'b1_1_1_10_1_101, 9'b1_1_1_00_1_000,
    9'b1_1_1_10_0_010, 9'b1_1_1_01_1_001, 9'b1_1_1_10_0_100, 9'b1_0_1_00_1_000,
    9'b0_1_1_01_1_001, 9'b1_1_0_10_1_010, 9'b0_0_1_00_0_100, 9'b1_0_0_01_0_000,
    9'b0_1_0_10_1_000, 9'b0_0_0_00_1_111, 9'b0_0_0_10_1_000, 9'b0_0_0_00_0_000
  };

  axi_mm_packet_master axi_mm_packet_master_i (.*);

  always #2 clk_wr = ~clk_wr;

  //////////////////////////////
  // Random data and models
  //////////////////////////////
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [159:0] random_wide();
    logic [159:0] v;
    for (int k = 0; k < 5; k++)
      v[32*k +: 32] = next_random();
    return v;
  endfunction

  // First requester at or after the pointer or -1 when idle
  function automatic int model_grant(input logic [N_TX_REQ-1:0] req, input int ptr);
    int idx;
    for (int k = 0; k < N_TX_REQ; k++)
    begin
      idx = (ptr + k) % N_TX_REQ;
      if (req[idx])
        return idx;
    end
    return -1;
  endfunction

  function automatic logic [PKT_WIDTH-1:0] expected_payload(input tx_pkt_e id);
    logic [PKT_WIDTH-1:0] p;
    p = '0;
    case (id)
      PKT_AR:    p[49:0] = {tx_ar_pushbit, tx_ar_data};
      PKT_AW:    p[49:0] = {tx_aw_pushbit, tx_aw_data};
      PKT_W_HDR: p[3:0] = {tx_w_pushbit, tx_w_data[148:146]};
      PKT_W_MID: p = tx_w_data[145:73];
      PKT_W_LOW: p = tx_w_data[72:0];
      default:   p = '0;
    endcase
    return p;
  endfunction

  function automatic logic [PHY_WIDTH-1:0] expected_phy(input tx_pkt_e id,
                                                        input logic [PKT_WIDTH-1:0] payload);
    logic [PHY_WIDTH-1:0] w;
    w      = '0;
    w[0]   = tx_mrk_userbit;
    w[3:1] = id;
    w[75:4] = payload[71:0];
    w[76]  = tx_stb_userbit;
    w[77]  = payload[72];
    w[78]  = tx_r_credit;
    w[79]  = tx_b_credit;
    return w;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      mismatch_count++;
      $display("mismatch %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
    end
  endtask

  task automatic check_data(input string name, input logic [R_WIDTH-1:0] got,
                            input logic [R_WIDTH-1:0] exp);
    if (got !== exp)
    begin
      mismatch_count++;
      $display("mismatch %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
    end
  endtask

  task automatic check_tx_id(input tx_pkt_e got, input tx_pkt_e exp);
    if (got !== exp)
    begin
      mismatch_count++;
      $display("mismatch tx_phy0 id at %0t: got 0x%h (%s), expected 0x%h (%s)",
               $time, got, got.name(), exp, exp.name());
    end
  endtask

  // Each push override drops only for its own packet id
  task automatic check_rx_id_effects(input rx_pkt_e id);
    check_bit("rx_b_push_ovrd", rx_b_push_ovrd, id != RX_PKT_B);
    check_bit("rx_r_push_ovrd", rx_r_push_ovrd, id != RX_PKT_R_LO);
  endtask

  //////////////////////////////
  // One cycle of stimulus and checks
  //////////////////////////////
  task automatic apply_row(input row_t row);
    logic [159:0]         wide;
    logic [31:0]          bits;
    logic [PKT_WIDTH-1:0] rx_payload;
    rx_pkt_e              rx_id;
    logic [N_TX_REQ-1:0]  req;
    int                   g;
    tx_pkt_e              exp_id;
    logic [PKT_WIDTH-1:0] exp_payload;
    @(negedge clk_wr);
    // Items popped last cycle leave their sources
    if (ar_taken)
      tx_ar_pushbit = 1'b0;
    if (aw_taken)
      tx_aw_pushbit = 1'b0;
    if (w_taken)
      tx_w_pushbit = 1'b0;
    if (!tx_ar_pushbit && row.ar)
    begin
      wide          = random_wide();
      tx_ar_data    = wide[AR_WIDTH-1:0];
      tx_ar_pushbit = 1'b1;
    end
    if (!tx_aw_pushbit && row.aw)
    begin
      wide          = random_wide();
      tx_aw_data    = wide[AW_WIDTH-1:0];
      tx_aw_pushbit = 1'b1;
    end
    if (!tx_w_pushbit && row.w)
    begin
      wide         = random_wide();
      tx_w_data    = wide[W_WIDTH-1:0];
      tx_w_pushbit = 1'b1;
    end
    rx_id          = rx_pkt_e'(row.rx_id);
    wide           = random_wide();
    rx_payload     = wide[PKT_WIDTH-1:0];
    // Table bit drives the push position of the packet's own channel
    if (rx_id == RX_PKT_B)
    begin
      rx_payload[6]  = row.rx_push;
      rx_payload[62] = 1'b1;
    end
    else
    begin
      rx_payload[6]  = !row.rx_push;
      rx_payload[62] = row.rx_push;
    end
    bits           = next_random();
    rx_phy0        = {row.rx_credit, bits[1], rx_payload, rx_id, bits[0]};
    tx_mrk_userbit = bits[2];
    tx_stb_userbit = bits[3];
    tx_r_credit    = bits[4];
    tx_b_credit    = bits[5];
    #1;
    req         = {low_req_m, mid_req_m, tx_w_pushbit, tx_aw_pushbit, tx_ar_pushbit};
    g           = model_grant(req, ptr_m);
    exp_id      = (g < 0) ? PKT_AR : tx_pkt_e'(g[2:0]);
    exp_payload = expected_payload(exp_id);
    check_tx_id(tx_pkt_e'(tx_phy0[3:1]), exp_id);
    check_data("tx_phy0", R_WIDTH'(tx_phy0), R_WIDTH'(expected_phy(exp_id, exp_payload)));
    check_bit("tx_ar_pop_ovrd", tx_ar_pop_ovrd, exp_id != PKT_AR);
    check_bit("tx_aw_pop_ovrd", tx_aw_pop_ovrd, exp_id != PKT_AW);
    check_bit("tx_w_pop_ovrd", tx_w_pop_ovrd, exp_id != PKT_W_LOW);
    check_bit("rx_ar_credit", rx_ar_credit, row.rx_credit[0]);
    check_bit("rx_aw_credit", rx_aw_credit, row.rx_credit[1]);
    check_bit("rx_w_credit", rx_w_credit, row.rx_credit[2]);
    check_rx_id_effects(rx_id);
    check_data("rx_b_data", R_WIDTH'(rx_b_data), R_WIDTH'(rx_payload[5:0]));
    check_bit("rx_b_pushbit", rx_b_pushbit, (rx_id == RX_PKT_B) && rx_payload[6]);
    check_bit("rx_r_pushbit", rx_r_pushbit, (rx_id == RX_PKT_R_LO) &&
              (prev_id_m == RX_PKT_R_HI) && prev_payload_m[62]);
    check_data("rx_r_data", rx_r_data, {prev_payload_m[61:0], rx_payload});
    // Sources see their pop override before the edge
    ar_taken = tx_ar_pushbit && !tx_ar_pop_ovrd;
    aw_taken = tx_aw_pushbit && !tx_aw_pop_ovrd;
    w_taken  = tx_w_pushbit && !tx_w_pop_ovrd;
    // Model state after the coming rising edge
    mid_req_m = (exp_id == PKT_W_HDR) && tx_w_pushbit;
    low_req_m = (exp_id == PKT_W_MID);
    if (g >= 0)
      ptr_m = (g + 1) % N_TX_REQ;
    prev_id_m      = rx_id;
    prev_payload_m = rx_payload;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial
  begin
    int drain_cycles;
    clk_wr         = 1'b0;
    rst_wr_n       = 1'b0;
    tx_ar_data     = '0;
    tx_ar_pushbit  = 1'b0;
    tx_aw_data     = '0;
    tx_aw_pushbit  = 1'b0;
    tx_w_data      = '0;
    tx_w_pushbit   = 1'b0;
    tx_r_credit    = 1'b0;
    tx_b_credit    = 1'b0;
    rx_phy0        = '0;
    tx_stb_userbit = 1'b0;
    tx_mrk_userbit = 1'b0;
    rng_state      = 32'hfd6b;
    ptr_m          = 0;
    mid_req_m      = 1'b0;
    low_req_m      = 1'b0;
    prev_id_m      = RX_PKT_B;
    prev_payload_m = '0;
    ar_taken       = 1'b0;
    aw_taken       = 1'b0;
    w_taken        = 1'b0;
    mismatch_count = 0;
    timeout_count  = 0;
    repeat (16) @(posedge clk_wr);
    @(negedge clk_wr);
    rst_wr_n = 1'b1;
    #1;
    // Idle word right after reset
    check_data("tx_phy0", R_WIDTH'(tx_phy0), '0);
    check_tx_id(tx_pkt_e'(tx_phy0[3:1]), PKT_AR);
    check_bit("tx_ar_pop_ovrd", tx_ar_pop_ovrd, 1'b0);
    check_bit("tx_aw_pop_ovrd", tx_aw_pop_ovrd, 1'b1);
    check_bit("tx_w_pop_ovrd", tx_w_pop_ovrd, 1'b1);
    check_bit("rx_b_pushbit", rx_b_pushbit, 1'b0);
    check_bit("rx_r_pushbit", rx_r_pushbit, 1'b0);
    foreach (stim_table[i])
      apply_row(stim_table[i]);
    // Idle rows until every source has been popped
    drain_cycles = 0;
    while ((tx_ar_pushbit || tx_aw_pushbit || tx_w_pushbit) && drain_cycles < drain_limit)
    begin
      apply_row('0);
      drain_cycles++;
    end
    if (tx_ar_pushbit || tx_aw_pushbit || tx_w_pushbit)
    begin
      timeout_count++;
      $display("timeout: transmit sources still pending after %0d idle cycles", drain_limit);
    end
    $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// ==== src/axi_mm_packet_master.sv ====
`timescale 1ns/100ps

module axi_mm_packet_master
  import pkt_pkg::*;
(
  // Transmit request channels
  input  logic [AR_WIDTH-1:0]  tx_ar_data,
  input  logic                 tx_ar_pushbit,
  output logic                 tx_ar_pop_ovrd,
  input  logic [AW_WIDTH-1:0]  tx_aw_data,
  input  logic                 tx_aw_pushbit,
  output logic                 tx_aw_pop_ovrd,
  input  logic [W_WIDTH-1:0]   tx_w_data,
  input  logic                 tx_w_pushbit,
  output logic                 tx_w_pop_ovrd,
  // Credits returned for the request channels
  output logic                 rx_ar_credit,
  output logic                 rx_aw_credit,
  output logic                 rx_w_credit,
  // Responses
  output logic [R_WIDTH-1:0]   rx_r_data,
  output logic                 rx_r_push_ovrd,
  output logic                 rx_r_pushbit,
  output logic [B_WIDTH-1:0]   rx_b_data,
  output logic                 rx_b_push_ovrd,
  output logic                 rx_b_pushbit,
  input  logic                 tx_r_credit,
  input  logic                 tx_b_credit,
  // PHY
  output logic [PHY_WIDTH-1:0] tx_phy0,
  input  logic [PHY_WIDTH-1:0] rx_phy0,
  input  logic                 clk_wr,
  input  logic                 rst_wr_n,
  input  logic                 tx_stb_userbit,
  input  logic                 tx_mrk_userbit
);

  tx_pkt_e              tx_pkt_id;
  logic [PKT_WIDTH-1:0] tx_payload;
  rx_pkt_e              rx_pkt_id;
  logic [PKT_WIDTH-1:0] rx_payload;

  //////////////////////////////
  // Transmit path
  //////////////////////////////
  tx_packetizer u_tx_packetizer (
    .clk_wr      (clk_wr),
    .rst_wr_n    (rst_wr_n),
    .ar_data     (tx_ar_data),
    .ar_pushbit  (tx_ar_pushbit),
    .aw_data     (tx_aw_data),
    .aw_pushbit  (tx_aw_pushbit),
    .w_data      (tx_w_data),
    .w_pushbit   (tx_w_pushbit),
    .ar_pop_ovrd (tx_ar_pop_ovrd),
    .aw_pop_ovrd (tx_aw_pop_ovrd),
    .w_pop_ovrd  (tx_w_pop_ovrd),
    .pkt_id      (tx_pkt_id),
    .payload     (tx_payload)
  );

  tx_phy_framer #(.reg_phy(1'b0)) u_tx_phy_framer (
    .clk_wr      (clk_wr),
    .rst_wr_n    (rst_wr_n),
    .pkt_id      (tx_pkt_id),
    .payload     (tx_payload),
    .mrk_userbit (tx_mrk_userbit),
    .stb_userbit (tx_stb_userbit),
    .r_credit    (tx_r_credit),
    .b_credit    (tx_b_credit),
    .phy_word    (tx_phy0)
  );

  //////////////////////////////
  // Receive path
  //////////////////////////////
  rx_phy_deframer #(.reg_phy(1'b0)) u_rx_phy_deframer (
    .clk_wr    (clk_wr),
    .rst_wr_n  (rst_wr_n),
    .phy_word  (rx_phy0),
    .pkt_id    (rx_pkt_id),
    .payload   (rx_payload),
    .ar_credit (rx_ar_credit),
    .aw_credit (rx_aw_credit),
    .w_credit  (rx_w_credit)
  );

  rx_depacketizer u_rx_depacketizer (
    .clk_wr      (clk_wr),
    .rst_wr_n    (rst_wr_n),
    .pkt_id      (rx_pkt_id),
    .payload     (rx_payload),
    .r_data      (rx_r_data),
    .r_push_ovrd (rx_r_push_ovrd),
    .r_pushbit   (rx_r_pushbit),
    .b_data      (rx_b_data),
    .b_push_ovrd (rx_b_push_ovrd),
    .b_pushbit   (rx_b_pushbit)
  );

endmodule

// ==== src/rx_depacketizer.sv ====
`timescale 1ns/100ps

module rx_depacketizer
  import pkt_pkg::*;
(
  input  logic                 clk_wr,
  input  logic                 rst_wr_n,
  input  rx_pkt_e              pkt_id,
  input  logic [PKT_WIDTH-1:0] payload,
  output logic [R_WIDTH-1:0]   r_data,
  output logic                 r_push_ovrd,
  output logic                 r_pushbit,
  output logic [B_WIDTH-1:0]   b_data,
  output logic                 b_push_ovrd,
  output logic                 b_pushbit
);

  rx_pkt_e              prev_id;
  logic [PKT_WIDTH-1:0] prev_payload;

  //////////////////////////////
  // One packet history
  //////////////////////////////
  always_ff @(posedge clk_wr or negedge rst_wr_n)
  begin
    if (!rst_wr_n)
    begin
      prev_id <= RX_PKT_B;
    end
    else
    begin
      prev_id <= pkt_id;
    end
  end

  always_ff @(posedge clk_wr)
  begin
    prev_payload <= payload;
  end

  // Write response fits in one packet
  assign b_push_ovrd = (pkt_id != RX_PKT_B);
  assign b_pushbit   = (pkt_id == RX_PKT_B) && payload[B_PUSH_LOC];
  assign b_data      = payload[B_WIDTH-1:0];

  // Read response is HI then LO, push qualified by the HI packet
  assign r_push_ovrd = (pkt_id != RX_PKT_R_LO);
  assign r_pushbit   = (pkt_id == RX_PKT_R_LO) && (prev_id == RX_PKT_R_HI) &&
                       prev_payload[R_HI_PUSH_LOC];
  assign r_data      = {prev_payload[R_HI_WIDTH-1:0], payload};

  a_r_push_after_hi: assert property (
    @(posedge clk_wr) disable iff (!rst_wr_n)
    r_pushbit |-> $past(pkt_id) == RX_PKT_R_HI
  );

endmodule

// ==== src/rx_phy_deframer.sv ====
`timescale 1ns/100ps

module rx_phy_deframer
  import pkt_pkg::*;
#(
  parameter bit reg_phy = 1'b0
)
(
  input  logic                 clk_wr,
  input  logic                 rst_wr_n,
  input  logic [PHY_WIDTH-1:0] phy_word,
  output rx_pkt_e              pkt_id,
  output logic [PKT_WIDTH-1:0] payload,
  output logic                 ar_credit,
  output logic                 aw_credit,
  output logic                 w_credit
);

  logic [PHY_WIDTH-1:0] word;

  // Optional boundary flop from the PHY
  if (reg_phy)
  begin : g_reg
    always_ff @(posedge clk_wr or negedge rst_wr_n)
    begin
      if (!rst_wr_n)
      begin
        word <= '0;
      end
      else
      begin
        word <= phy_word;
      end
    end
  end
  else
  begin : g_comb
    assign word = phy_word;
  end

  // Marker at bit 0 and strobe at bit 76 are dropped
  assign pkt_id    = rx_pkt_e'(word[RX_ID_LOC +: $bits(rx_pkt_e)]);
  assign payload   = word[RX_PAYLOAD_LOC +: PKT_WIDTH];
  assign ar_credit = word[RX_AR_CREDIT_LOC];
  assign aw_credit = word[RX_AW_CREDIT_LOC];
  assign w_credit  = word[RX_W_CREDIT_LOC];

endmodule

// ==== src/tx_phy_framer.sv ====
`timescale 1ns/100ps

module tx_phy_framer
  import pkt_pkg::*;
#(
  parameter bit reg_phy = 1'b0
)
(
  input  logic                 clk_wr,
  input  logic                 rst_wr_n,
  input  tx_pkt_e              pkt_id,
  input  logic [PKT_WIDTH-1:0] payload,
  input  logic                 mrk_userbit,
  input  logic                 stb_userbit,
  input  logic                 r_credit,
  input  logic                 b_credit,
  output logic [PHY_WIDTH-1:0] phy_word
);

  logic [PHY_WIDTH-1:0] word_c;

  // Payload is split around the strobe position
  always_comb
  begin
    word_c                                       = '0;
    word_c[MARKER_LOC]                           = mrk_userbit;
    word_c[TX_ID_LOC +: $bits(tx_pkt_e)]         = pkt_id;
    word_c[TX_PAYLOAD_LO_LOC +: PKT_WIDTH - 1]   = payload[PKT_WIDTH-2:0];
    word_c[STROBE_LOC]                           = stb_userbit;
    word_c[TX_PAYLOAD_HI_LOC]                    = payload[PKT_WIDTH-1];
    word_c[TX_R_CREDIT_LOC]                      = r_credit;
    word_c[TX_B_CREDIT_LOC]                      = b_credit;
  end

  // Optional boundary flop toward the PHY
  if (reg_phy)
  begin : g_reg
    always_ff @(posedge clk_wr or negedge rst_wr_n)
    begin
      if (!rst_wr_n)
      begin
        phy_word <= '0;
      end
      else
      begin
        phy_word <= word_c;
      end
    end
  end
  else
  begin : g_comb
    assign phy_word = word_c;
  end

endmodule

// ==== src/tx_packetizer.sv ====
`timescale 1ns/100ps

module tx_packetizer
  import pkt_pkg::*;
(
  input  logic                 clk_wr,
  input  logic                 rst_wr_n,
  input  logic [AR_WIDTH-1:0]  ar_data,
  input  logic                 ar_pushbit,
  input  logic [AW_WIDTH-1:0]  aw_data,
  input  logic                 aw_pushbit,
  input  logic [W_WIDTH-1:0]   w_data,
  input  logic                 w_pushbit,
  output logic                 ar_pop_ovrd,
  output logic                 aw_pop_ovrd,
  output logic                 w_pop_ovrd,
  output tx_pkt_e              pkt_id,
  output logic [PKT_WIDTH-1:0] payload
);

  logic [N_TX_REQ-1:0]  request;
  logic                 w_mid_req;
  logic                 w_low_req;
  logic [PKT_WIDTH-1:0] ar_pkt;
  logic [PKT_WIDTH-1:0] aw_pkt;
  logic [PKT_WIDTH-1:0] w_hdr_pkt;
  logic [PKT_WIDTH-1:0] w_mid_pkt;
  logic [PKT_WIDTH-1:0] w_low_pkt;

  //////////////////////////////
  // Request and arbitration
  //////////////////////////////
  assign request = {w_low_req, w_mid_req, w_pushbit, aw_pushbit, ar_pushbit};

  rr_arbiter u_rr_arbiter (
    .clk_wr   (clk_wr),
    .rst_wr_n (rst_wr_n),
    .request  (request),
    .grant    (pkt_id)
  );

  // Follow-on slices request one cycle behind the previous slice
  always_ff @(posedge clk_wr or negedge rst_wr_n)
  begin
    if (!rst_wr_n)
    begin
      w_mid_req <= 1'b0;
      w_low_req <= 1'b0;
    end
    else
    begin
      w_mid_req <= (pkt_id == PKT_W_HDR) & w_pushbit;
      w_low_req <= (pkt_id == PKT_W_MID) & w_mid_req;
    end
  end

  //////////////////////////////
  // Packet payloads
  //////////////////////////////
  assign ar_pkt    = {(PKT_WIDTH - AR_WIDTH - 1)'(0), ar_pushbit, ar_data};
  assign aw_pkt    = {(PKT_WIDTH - AW_WIDTH - 1)'(0), aw_pushbit, aw_data};
  assign w_hdr_pkt = {(PKT_WIDTH - W_HDR_WIDTH - 1)'(0), w_pushbit,
                      w_data[W_WIDTH-1 -: W_HDR_WIDTH]};
  assign w_mid_pkt = w_data[PKT_WIDTH +: PKT_WIDTH];
  assign w_low_pkt = w_data[0 +: PKT_WIDTH];

  always_comb
  begin
    case (pkt_id)
      PKT_AR:    payload = ar_pkt;
      PKT_AW:    payload = aw_pkt;
      PKT_W_HDR: payload = w_hdr_pkt;
      PKT_W_MID: payload = w_mid_pkt;
      PKT_W_LOW: payload = w_low_pkt;
      default:   payload = '0;
    endcase
  end

  // Source is consumed only on its last packet
  assign ar_pop_ovrd = (pkt_id != PKT_AR);
  assign aw_pop_ovrd = (pkt_id != PKT_AW);
  assign w_pop_ovrd  = (pkt_id != PKT_W_LOW);

  // A LOW slice always follows MID, which follows HDR
  a_w_low_order: assert property (
    @(posedge clk_wr) disable iff (!rst_wr_n)
    w_low_req |-> ($past(pkt_id) == PKT_W_MID) && ($past(pkt_id, 2) == PKT_W_HDR)
  );

endmodule

// ==== src/rr_arbiter.sv ====
`timescale 1ns/100ps

module rr_arbiter
  import pkt_pkg::*;
(
  input  logic                clk_wr,
  input  logic                rst_wr_n,
  input  logic [N_TX_REQ-1:0] request,
  output tx_pkt_e             grant
);

  // Index that currently has the highest priority
  logic [2:0]          ptr;
  logic [N_TX_REQ-1:0] grant_oh;

  // Scan from the top so the first requester at or after ptr wins last
  always_comb
  begin
    grant_oh = '0;
    for (int i = N_TX_REQ - 1; i >= 0; i--)
    begin
      if (request[(int'(ptr) + i) % N_TX_REQ])
      begin
        grant_oh = '0;
        grant_oh[(int'(ptr) + i) % N_TX_REQ] = 1'b1;
      end
    end
  end

  // One-hot to packet id, idle falls back to AR
  always_comb
  begin
    case (grant_oh)
      5'b00001: grant = PKT_AR;
      5'b00010: grant = PKT_AW;
      5'b00100: grant = PKT_W_HDR;
      5'b01000: grant = PKT_W_MID;
      5'b10000: grant = PKT_W_LOW;
      default:  grant = PKT_AR;
    endcase
  end

  // Priority moves past the winner, holds when idle
  always_ff @(posedge clk_wr or negedge rst_wr_n)
  begin
    if (!rst_wr_n)
    begin
      ptr <= '0;
    end
    else if (|request)
    begin
      if (grant == PKT_W_LOW)
      begin
        ptr <= '0;
      end
      else
      begin
        ptr <= grant + 3'd1;
      end
    end
  end

  a_grant_is_requester: assert property (
    @(posedge clk_wr) disable iff (!rst_wr_n)
    |request |-> request[grant]
  );

endmodule

// ==== src/pkt_pkg.sv ====
package pkt_pkg;

  //////////////////////////////
  // Channel widths
  //////////////////////////////
  localparam int PHY_WIDTH   = 80;
  localparam int PKT_WIDTH   = 73;
  localparam int AR_WIDTH    = 49;
  localparam int AW_WIDTH    = 49;
  localparam int W_WIDTH     = 149;
  localparam int R_WIDTH     = 135;
  localparam int B_WIDTH     = 6;
  // Top write bits that ride in the header packet
  localparam int W_HDR_WIDTH = 3;
  localparam int N_TX_REQ    = 5;

  // Transmit word layout
  localparam int MARKER_LOC        = 0;
  localparam int TX_ID_LOC         = 1;
  localparam int TX_PAYLOAD_LO_LOC = 4;
  localparam int STROBE_LOC        = 76;
  localparam int TX_PAYLOAD_HI_LOC = 77;
  localparam int TX_R_CREDIT_LOC   = 78;
  localparam int TX_B_CREDIT_LOC   = 79;

  // Receive word layout, marker and strobe unused
  localparam int RX_ID_LOC        = 1;
  localparam int RX_PAYLOAD_LOC   = 3;
  localparam int RX_AR_CREDIT_LOC = 77;
  localparam int RX_AW_CREDIT_LOC = 78;
  localparam int RX_W_CREDIT_LOC  = 79;

  // Push bits inside response payloads
  localparam int B_PUSH_LOC    = 6;
  localparam int R_HI_PUSH_LOC = 62;
  localparam int R_HI_WIDTH    = 62;

  //////////////////////////////
  // Packet ids
  //////////////////////////////
  typedef enum logic [2:0] {
    PKT_AR    = 3'd0,
    PKT_AW    = 3'd1,
    PKT_W_HDR = 3'd2,
    PKT_W_MID = 3'd3,
    PKT_W_LOW = 3'd4
  } tx_pkt_e;

  typedef enum logic [1:0] {
    RX_PKT_B    = 2'd0,
    RX_PKT_R_HI = 2'd1,
    RX_PKT_R_LO = 2'd2
  } rx_pkt_e;

endpackage
